/* src/gpio_link_consts.svh */
// bit timing, credit depths and command codes shared by the serial GPIO link and its bench
`ifndef GPIO_LINK_CONSTS_SVH
`define GPIO_LINK_CONSTS_SVH

// short bit period in clock cycles for simulation
`define BIT_DIV 16

// queue depths, which are also the initial credit counts
`define CMD_CREDITS 2
`define RESP_CREDITS 2

// command bytes from the host
`define OP_WR_LED 8'h4C
`define OP_RD_LED 8'h52
`define OP_RD_SW 8'h53

// fixed answers
`define RSP_ACK 8'h4B
`define RSP_BAD 8'h3F

// command kinds carried from decode to execute
`define KIND_WR_LED 2'd0
`define KIND_RD_LED 2'd1
`define KIND_RD_SW 2'd2
`define KIND_BAD 2'd3

`endif

/* src/gpio_link_pkg.sv */
// shared types of the serial GPIO link, imported by every RTL module and the testbench
package gpio_link_pkg;

  // ==========================================================================
  // payload vectors
  // ==========================================================================
  typedef logic [7:0] byte_t;
  typedef logic [7:0] led_t;
  typedef logic [3:0] sw_t;

  // decoded command kind as numbered by the KIND_ macros
  typedef logic [1:0] op_t;

  // ==========================================================================
  // state machines
  // ==========================================================================
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  typedef enum logic {
    DEC_OPCODE,
    DEC_OPERAND
  } dec_state_e;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

endpackage

/* src/uart_rx.sv */
// 8N1 serial receiver that strobes one byte per good frame into the command decoder
`timescale 1ns/100ps
`include "gpio_link_consts.svh"

module uart_rx
  import gpio_link_pkg::*;
(
  input  logic  clk,
  input  logic  i_arst_n,
  input  logic  i_rx,
  output byte_t o_rx_byte,
  output logic  o_rx_valid
);

  localparam int DIV_W = $clog2(`BIT_DIV);
  localparam logic [DIV_W-1:0] HALF_BIT = DIV_W'(`BIT_DIV / 2 - 1);
  localparam logic [DIV_W-1:0] FULL_BIT = DIV_W'(`BIT_DIV - 1);

  logic             rx_meta;
  logic             rx_sync;
  rx_state_e        state_q;
  logic [DIV_W-1:0] div_cnt;
  logic [2:0]       bit_idx;
  byte_t            shift_q;

  // line idles high, so the synchronizer resets to one
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= i_rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q    <= RX_IDLE;
      div_cnt    <= '0;
      bit_idx    <= '0;
      o_rx_valid <= 1'b0;
    end else begin
      o_rx_valid <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          div_cnt <= '0;
          if (!rx_sync) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          if (div_cnt == HALF_BIT) begin
            div_cnt <= '0;
            bit_idx <= '0;
            // a start bit gone high by mid-bit was a glitch
            state_q <= rx_sync ? RX_IDLE : RX_DATA;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (div_cnt == FULL_BIT) begin
            div_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        default: begin
          if (div_cnt == FULL_BIT) begin
            // low stop bit drops the byte
            o_rx_valid <= rx_sync;
            state_q    <= RX_IDLE;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // lsb first, sampled at bit centers
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && div_cnt == FULL_BIT) begin
      shift_q <= {rx_sync, shift_q[7:1]};
    end
  end

  assign o_rx_byte = shift_q;

endmodule

/* src/cmd_decode.sv */
// decode stage that turns received bytes into commands and issues them to execute on credit
`timescale 1ns/100ps
`include "gpio_link_consts.svh"

module cmd_decode
  import gpio_link_pkg::*;
(
  input  logic  clk,
  input  logic  i_arst_n,
  input  byte_t i_rx_byte,
  input  logic  i_rx_valid,
  input  logic  i_cmd_credit,
  output logic  o_cmd_valid,
  output op_t   o_cmd_op,
  output led_t  o_cmd_data
);

  localparam int CW = $clog2(`CMD_CREDITS + 1);
  localparam logic [CW-1:0] CRED_FULL = CW'(`CMD_CREDITS);

  dec_state_e    state_q;
  logic [CW-1:0] cred_q;
  logic          complete;
  logic          issue;
  op_t           kind;

  // classify the byte and see whether it closes a command
  always_comb begin
    kind     = `KIND_BAD;
    complete = 1'b0;
    if (i_rx_valid) begin
      if (state_q == DEC_OPERAND) begin
        kind     = `KIND_WR_LED;
        complete = 1'b1;
      end else begin
        case (i_rx_byte)
          `OP_WR_LED: complete = 1'b0;
          `OP_RD_LED: begin
            kind     = `KIND_RD_LED;
            complete = 1'b1;
          end
          `OP_RD_SW: begin
            kind     = `KIND_RD_SW;
            complete = 1'b1;
          end
          default: complete = 1'b1;
        endcase
      end
    end
  end

  assign issue = complete && (cred_q != '0);

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q     <= DEC_OPCODE;
      cred_q      <= CRED_FULL;
      o_cmd_valid <= 1'b0;
    end else begin
      o_cmd_valid <= issue;
      if (i_rx_valid) begin
        // the byte after a write opcode is always data
        if (state_q == DEC_OPERAND) begin
          state_q <= DEC_OPCODE;
        end else if (i_rx_byte == `OP_WR_LED) begin
          state_q <= DEC_OPERAND;
        end
      end
      case ({issue, i_cmd_credit})
        2'b10:   cred_q <= cred_q - 1'b1;
        2'b01:   cred_q <= cred_q + 1'b1;
        default: cred_q <= cred_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      o_cmd_op   <= kind;
      o_cmd_data <= i_rx_byte;
    end
  end

  // the serial line cannot be held off, so a finished command must find a credit
  a_no_drop: assert property (@(posedge clk) disable iff (!i_arst_n)
    complete |-> cred_q != '0)
    else $error("cmd_decode: command dropped for lack of credit");

  // execute never returns more credits than were spent
  a_cred_bound: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_cmd_credit |-> cred_q != CRED_FULL)
    else $error("cmd_decode: credit returned with counter full");

endmodule

/* src/gpio_exec.sv */
// execute stage holding the LED register, the switch synchronizer and the command queue
`timescale 1ns/100ps
`include "gpio_link_consts.svh"

module gpio_exec
  import gpio_link_pkg::*;
(
  input  logic  clk,
  input  logic  i_arst_n,
  input  logic  i_cmd_valid,
  input  op_t   i_cmd_op,
  input  led_t  i_cmd_data,
  input  sw_t   i_sw,
  input  logic  i_rsp_credit,
  output logic  o_cmd_credit,
  output logic  o_rsp_valid,
  output byte_t o_rsp_byte,
  output led_t  o_led
);

  localparam int QA_W = (`CMD_CREDITS > 1) ? $clog2(`CMD_CREDITS) : 1;
  localparam int QC_W = $clog2(`CMD_CREDITS + 1);
  localparam int RC_W = $clog2(`RESP_CREDITS + 1);
  localparam logic [QA_W-1:0] Q_LAST = QA_W'(`CMD_CREDITS - 1);
  localparam logic [QC_W-1:0] Q_FULL = QC_W'(`CMD_CREDITS);

  op_t             op_mem   [`CMD_CREDITS];
  led_t            data_mem [`CMD_CREDITS];
  logic [QA_W-1:0] wr_ptr;
  logic [QA_W-1:0] rd_ptr;
  logic [QC_W-1:0] q_cnt;
  logic [RC_W-1:0] rsp_cred;
  sw_t             sw_meta;
  sw_t             sw_sync;
  led_t            led_q;
  logic            pop;
  byte_t           result;

  // execute only when the result stage has room
  assign pop = (q_cnt != '0) && (rsp_cred != '0);

  always_comb begin
    case (op_mem[rd_ptr])
      `KIND_WR_LED: result = `RSP_ACK;
      `KIND_RD_LED: result = led_q;
      `KIND_RD_SW:  result = {4'h0, sw_sync};
      default:      result = `RSP_BAD;
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_cmd_valid) begin
      op_mem[wr_ptr]   <= i_cmd_op;
      data_mem[wr_ptr] <= i_cmd_data;
    end
    if (pop) begin
      o_rsp_byte <= result;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      q_cnt        <= '0;
      rsp_cred     <= RC_W'(`RESP_CREDITS);
      sw_meta      <= '0;
      sw_sync      <= '0;
      led_q        <= '0;
      o_cmd_credit <= 1'b0;
      o_rsp_valid  <= 1'b0;
    end else begin
      sw_meta      <= i_sw;
      sw_sync      <= sw_meta;
      o_cmd_credit <= pop;
      o_rsp_valid  <= pop;
      if (i_cmd_valid) begin
        wr_ptr <= (wr_ptr == Q_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == Q_LAST) ? '0 : rd_ptr + 1'b1;
        if (op_mem[rd_ptr] == `KIND_WR_LED) begin
          led_q <= data_mem[rd_ptr];
        end
      end
      case ({i_cmd_valid, pop})
        2'b10:   q_cnt <= q_cnt + 1'b1;
        2'b01:   q_cnt <= q_cnt - 1'b1;
        default: q_cnt <= q_cnt;
      endcase
      case ({pop, i_rsp_credit})
        2'b10:   rsp_cred <= rsp_cred - 1'b1;
        2'b01:   rsp_cred <= rsp_cred + 1'b1;
        default: rsp_cred <= rsp_cred;
      endcase
    end
  end

  assign o_led = led_q;

  // decode's credit count must keep it off a full queue
  a_q_overflow: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_cmd_valid |-> q_cnt != Q_FULL)
    else $error("gpio_exec: command pushed into full queue");

endmodule

/* src/resp_tx.sv */
// result stage that buffers response bytes and sends them out as 8N1 frames
`timescale 1ns/100ps
`include "gpio_link_consts.svh"

module resp_tx
  import gpio_link_pkg::*;
(
  input  logic  clk,
  input  logic  i_arst_n,
  input  logic  i_rsp_valid,
  input  byte_t i_rsp_byte,
  output logic  o_rsp_credit,
  output logic  o_tx
);

  localparam int BA_W = (`RESP_CREDITS > 1) ? $clog2(`RESP_CREDITS) : 1;
  localparam int BC_W = $clog2(`RESP_CREDITS + 1);
  localparam int DIV_W = $clog2(`BIT_DIV);
  localparam logic [BA_W-1:0] B_LAST = BA_W'(`RESP_CREDITS - 1);
  localparam logic [BC_W-1:0] B_FULL = BC_W'(`RESP_CREDITS);
  localparam logic [DIV_W-1:0] FULL_BIT = DIV_W'(`BIT_DIV - 1);

  byte_t            buf_mem [`RESP_CREDITS];
  logic [BA_W-1:0]  wr_ptr;
  logic [BA_W-1:0]  rd_ptr;
  logic [BC_W-1:0]  buf_cnt;
  tx_state_e        state_q;
  logic [DIV_W-1:0] div_cnt;
  logic [2:0]       bit_idx;
  byte_t            shift_q;
  logic             bit_end;
  logic             load;

  assign bit_end = (div_cnt == FULL_BIT);

  // next frame may follow the stop bit directly
  assign load = (buf_cnt != '0) &&
                ((state_q == TX_IDLE) || (state_q == TX_STOP && bit_end));

  // ==========================================================================
  // response buffer
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (i_rsp_valid) begin
      buf_mem[wr_ptr] <= i_rsp_byte;
    end
    if (load) begin
      shift_q <= buf_mem[rd_ptr];
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      buf_cnt <= '0;
    end else begin
      if (i_rsp_valid) begin
        wr_ptr <= (wr_ptr == B_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (load) begin
        rd_ptr <= (rd_ptr == B_LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({i_rsp_valid, load})
        2'b10:   buf_cnt <= buf_cnt + 1'b1;
        2'b01:   buf_cnt <= buf_cnt - 1'b1;
        default: buf_cnt <= buf_cnt;
      endcase
    end
  end

  // ==========================================================================
  // frame shifter
  // ==========================================================================
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q      <= TX_IDLE;
      div_cnt      <= '0;
      bit_idx      <= '0;
      o_tx         <= 1'b1;
      o_rsp_credit <= 1'b0;
    end else begin
      o_rsp_credit <= load;
      if (load) begin
        state_q <= TX_START;
        div_cnt <= '0;
        o_tx    <= 1'b0;
      end else begin
        case (state_q)
          TX_IDLE: begin
            div_cnt <= '0;
            o_tx    <= 1'b1;
          end
          TX_START: begin
            div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
            if (bit_end) begin
              state_q <= TX_DATA;
              bit_idx <= '0;
              o_tx    <= shift_q[0];
            end
          end
          TX_DATA: begin
            div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
            if (bit_end) begin
              if (bit_idx == 3'd7) begin
                state_q <= TX_STOP;
                o_tx    <= 1'b1;
              end else begin
                bit_idx <= bit_idx + 1'b1;
                o_tx    <= shift_q[bit_idx + 3'd1];
              end
            end
          end
          default: begin
            div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
            if (bit_end) begin
              state_q <= TX_IDLE;
            end
          end
        endcase
      end
    end
  end

  // execute holds a result credit for every byte it sends here
  a_buf_overflow: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_rsp_valid |-> buf_cnt != B_FULL)
    else $error("resp_tx: response pushed into full buffer");

endmodule

/* src/gpio_link_top.sv */
// top level of the serial GPIO link that chains the receiver, decode, execute and result stages
`timescale 1ns/100ps

module gpio_link_top
  import gpio_link_pkg::*;
(
  input  logic clk,
  input  logic i_arst_n,
  input  logic i_rx,
  input  sw_t  i_sw,
  output logic o_tx,
  output led_t o_led
);

  byte_t rx_byte;
  logic  rx_valid;
  logic  cmd_valid;
  op_t   cmd_op;
  led_t  cmd_data;
  logic  cmd_credit;
  logic  rsp_valid;
  byte_t rsp_byte;
  logic  rsp_credit;

  uart_rx u_rx (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_rx       (i_rx),
    .o_rx_byte  (rx_byte),
    .o_rx_valid (rx_valid)
  );

  cmd_decode u_dec (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_rx_byte    (rx_byte),
    .i_rx_valid   (rx_valid),
    .i_cmd_credit (cmd_credit),
    .o_cmd_valid  (cmd_valid),
    .o_cmd_op     (cmd_op),
    .o_cmd_data   (cmd_data)
  );

  gpio_exec u_exec (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_cmd_valid  (cmd_valid),
    .i_cmd_op     (cmd_op),
    .i_cmd_data   (cmd_data),
    .i_sw         (i_sw),
    .i_rsp_credit (rsp_credit),
    .o_cmd_credit (cmd_credit),
    .o_rsp_valid  (rsp_valid),
    .o_rsp_byte   (rsp_byte),
    .o_led        (o_led)
  );

  resp_tx u_tx (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_rsp_valid  (rsp_valid),
    .i_rsp_byte   (rsp_byte),
    .o_rsp_credit (rsp_credit),
    .o_tx         (o_tx)
  );

endmodule

/* tests/gpio_link_tb.sv */
// self-checking testbench for the serial GPIO link that sends commands and checks the replies
`timescale 1ns/100ps
`include "gpio_link_consts.svh"

module gpio_link_tb
  import gpio_link_pkg::*;
();

  localparam int N_RAND  = 40;
  localparam int N_CMDS  = 8 + N_RAND;
  localparam int TIMEOUT = N_CMDS * 40 * `BIT_DIV + 200;

  logic  clk;
  logic  i_arst_n;
  logic  i_rx;
  sw_t   i_sw;
  logic  o_tx;
  led_t  o_led;

  // responses still owed by the DUT in the order they are due
  byte_t exp_q[$];
  led_t  model_led;
  logic  led_check_armed;
  int    cycle_cnt = 0;

  gpio_link_top i_dut (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_rx     (i_rx),
    .i_sw     (i_sw),
    .o_tx     (o_tx),
    .o_led    (o_led)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ==========================================================================
  // failure reporting and compares
  // ==========================================================================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input byte_t exp_v, input byte_t act_v);
    if (act_v !== exp_v) begin
      abort_run($sformatf("Fail at %0t: %s expected 0x%02h, got 0x%02h",
                          $time, name, exp_v, act_v));
    end
  endtask

  task automatic check_led(input string name, input led_t exp_v, input led_t act_v);
    if (act_v !== exp_v) begin
      abort_run($sformatf("Fail at %0t: %s expected 0x%02h, got 0x%02h",
                          $time, name, exp_v, act_v));
    end
  endtask

  task automatic check_line(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      abort_run($sformatf("Fail at %0t: %s expected %b, got %b",
                          $time, name, exp_v, act_v));
    end
  endtask

  // answer the host should see for one command
  function automatic byte_t expected_response(input byte_t code, input led_t led_img,
                                              input sw_t sw);
    case (code)
      `OP_WR_LED: return `RSP_ACK;
      `OP_RD_LED: return led_img;
      `OP_RD_SW:  return {4'h0, sw};
      default:    return `RSP_BAD;
    endcase
  endfunction

  // ==========================================================================
  // serial driver
  // ==========================================================================
  task automatic send_byte(input byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      i_rx <= frame[i];
      repeat (`BIT_DIV - 1) @(posedge clk);
    end
  endtask

  task automatic send_cmd(input byte_t code, input byte_t operand);
    exp_q.push_back(expected_response(code, model_led, i_sw));
    if (code == `OP_WR_LED) begin
      model_led = operand;
    end
    send_byte(code);
    if (code == `OP_WR_LED) begin
      send_byte(operand);
    end
  endtask

  task automatic set_switches(input sw_t v);
    @(posedge clk);
    i_sw <= v;
    // settling gap for the two-flop synchronizer
    repeat (8) @(posedge clk);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
  endtask

  // ==========================================================================
  // response monitor sampling o_tx on falling edges
  // ==========================================================================
  initial begin : monitor
    byte_t got;
    @(posedge i_arst_n);
    forever begin
      @(negedge clk);
      if (!o_tx) begin
        if (exp_q.size() == 0) begin
          abort_run("a response frame started with no command outstanding");
        end
        if (led_check_armed) begin
          check_led("o_led", model_led, o_led);
          led_check_armed = 1'b0;
        end
        repeat (`BIT_DIV / 2) @(negedge clk);
        check_line("o_tx start bit", 1'b0, o_tx);
        for (int i = 0; i < 8; i++) begin
          repeat (`BIT_DIV) @(negedge clk);
          got[i] = o_tx;
        end
        repeat (`BIT_DIV) @(negedge clk);
        check_line("o_tx stop bit", 1'b1, o_tx);
        check_byte("o_tx response", exp_q.pop_front(), got);
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      abort_run("timeout: the responses did not all arrive within the cycle limit");
    end
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================
  initial begin : stimulus
    byte_t code;
    byte_t operand;
    int    kind;
    void'($urandom(86));
    i_arst_n        = 1'b0;
    i_rx            = 1'b1;
    i_sw            = 4'h0;
    model_led       = 8'h00;
    led_check_armed = 1'b0;
    repeat (3) @(posedge clk);
    i_arst_n <= 1'b1;

    // idle line after reset
    repeat (2 * `BIT_DIV) begin
      @(negedge clk);
      check_line("o_tx", 1'b1, o_tx);
      check_led("o_led", 8'h00, o_led);
    end

    // led write, then read back
    led_check_armed = 1'b1;
    send_cmd(`OP_WR_LED, 8'hA5);
    wait_drain();
    send_cmd(`OP_RD_LED, 8'h00);
    wait_drain();

    set_switches(4'h9);
    send_cmd(`OP_RD_SW, 8'h00);
    wait_drain();
    set_switches(4'h6);
    send_cmd(`OP_RD_SW, 8'h00);
    wait_drain();

    // unknown codes, and an operand that looks like a command
    send_cmd(8'h00, 8'h00);
    send_cmd(8'hC3, 8'h00);
    send_cmd(`OP_WR_LED, `OP_RD_SW);
    send_cmd(`OP_RD_LED, 8'h00);
    wait_drain();
    check_led("o_led", model_led, o_led);

    // back-to-back random commands
    for (int n = 0; n < N_RAND; n++) begin
      kind    = $urandom_range(0, 3);
      operand = byte_t'($urandom);
      case (kind)
        0:       code = `OP_WR_LED;
        1:       code = `OP_RD_LED;
        2:       code = `OP_RD_SW;
        default: code = 8'h80 | byte_t'($urandom_range(0, 127));
      endcase
      send_cmd(code, operand);
    end
    wait_drain();
    check_led("o_led", model_led, o_led);

    // no stray frame may follow
    repeat (4 * `BIT_DIV) @(negedge clk);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+src
src/gpio_link_pkg.sv
src/uart_rx.sv
src/cmd_decode.sv
src/gpio_exec.sv
src/resp_tx.sv
src/gpio_link_top.sv
tests/gpio_link_tb.sv

/* Makefile */
# Verilator build and run of the serial GPIO link testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      = gpio_link_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) src/gpio_link_consts.svh

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: PASS" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
